// ==== tb/pathBufferTests.txt ====
// Block: mode readyKind readyMask, then decryptor words, then stash words
// mode 1 read-write: 16 decryptor and 16 stash words; mode 2 read-only: 4 headers
// readyKind 0: encReady follows readyMask, one bit per cycle; readyKind 1: random
// A mode word of 0 ends the list
// Read-write, encryptor always ready
1 0 ffffffff
d0000000 d0000001 d0000002 d0000003 d0000004 d0000005 d0000006 d0000007
d0000008 d0000009 d000000a d000000b d000000c d000000d d000000e d000000f
5a000000 5a000011 5a000022 5a000033 5a000044 5a000055 5a000066 5a000077
5a000088 5a000099 5a0000aa 5a0000bb 5a0000cc 5a0000dd 5a0000ee 5a0000ff
// Read-only header access, encryptor always ready
2 0 ffffffff
4eade000 4eade001 4eade002 4eade003
// Read-write under back-pressure, ready 4 cycles out of 32
1 0 0000000f
1badb002 3c4d5e6f 01234567 89abcdef 76543210 fedcba98 0f0f0f0f f0f0f0f0
12121212 34343434 56565656 78787878 9a9a9a9a bcbcbcbc dededede 00000001
a5a5a5a5 5a5a5a5a 13579bdf 2468ace0 deadbeef cafef00d 0000ffff ffff0000
11111111 22222222 33333333 44444444 55555555 66666666 77777777 88888888
// Read-write, random encryptor ready
1 1 00000000
e0000000 e1000001 e2000002 e3000003 e4000004 e5000005 e6000006 e7000007
e8000008 e9000009 ea00000a eb00000b ec00000c ed00000d ee00000e ef00000f
b0b00000 b0b00101 b0b00202 b0b00303 b0b00404 b0b00505 b0b00606 b0b00707
b0b00808 b0b00909 b0b00a0a b0b00b0b b0b00c0c b0b00d0d b0b00e0e b0b00f0f
// Read-only header access, random encryptor ready
2 1 00000000
9e000001 9e000002 9e000003 9e000004
// End of list
0 0 0

// ==== filelist.f ====
logic/oramPathPkg.sv
logic/pathPortArbiter.sv
logic/pathBuffer.sv
logic/encInputQueue.sv
logic/pathBufferTop.sv
tb/tbClockGen.sv
tb/pathBufferTb.sv

// ==== Bender.yml ====
package:
  name: path_buffer_port

sources:
  - logic/oramPathPkg.sv
  - logic/pathPortArbiter.sv
  - logic/pathBuffer.sv
  - logic/encInputQueue.sv
  - logic/pathBufferTop.sv
  - target: test
    files:
      - tb/tbClockGen.sv
      - tb/pathBufferTb.sv

// ==== tb/pathBufferTb.sv ====
//==========================================================================
// Testbench for the path buffer subsystem: reads accesses from the tests
// file, drives decryptor, stash and encryptor ready, checks stash drain
// and encryptor word streams, idle flags and the cycle limit
//==========================================================================

module pathBufferTb import oramPathPkg::*; ();

	localparam int DataWidth    = 32;
	localparam int TreeLevels   = 3;
	localparam int BucketBursts = 4;
	localparam int QueueDepth   = 4;
	localparam int PathBursts   = (TreeLevels + 1) * BucketBursts;
	localparam int Headers      = TreeLevels + 1;       // One header burst per bucket
	localparam int HeadWords    = 3;                    // Mode, ready kind, ready mask
	localparam int TestWords    = 256;
	localparam logic [31:0] Seed = 32'h0ef8576d;

	logic                 Clock;
	logic                 rstN;
	accessModeT           mode;
	logic                 start;
	logic                 decValid;
	logic [DataWidth-1:0] decData;
	logic                 stashValid;
	logic [DataWidth-1:0] stashData;
	logic                 encReady;
	logic                 stashOutValid;
	logic [DataWidth-1:0] stashOutData;
	logic                 encValid;
	logic [DataWidth-1:0] encData;
	logic                 busy;

	logic [31:0]          testMem [TestWords];
	logic [DataWidth-1:0] expDrain [$];                 // Words due at the stash
	logic [DataWidth-1:0] expEnc [$];                   // Words due at the encryptor
	int                   drainSeen = 0;
	int                   encSeen = 0;
	int                   cycleCount = 0;
	int                   timeoutLimit = 0;
	int                   base;
	int                   accessCount;
	logic                 readyRandom = 1'b0;
	logic [31:0]          readyMask = '0;
	logic [4:0]           readyPhase = '0;

	tbClockGen u_clockGen (.Clock(Clock), .rstN(rstN));

	pathBufferTop #(
		.DataWidth(DataWidth),
		.TreeLevels(TreeLevels),
		.BucketBursts(BucketBursts),
		.QueueDepth(QueueDepth)
	) u_pathBufferTop (.*);

	//==========================================================================
	// Checks
	//==========================================================================

	task automatic failNow(input string what);
		$display("%s", what);
		$display("TESTBENCH FAILED");
		$fatal(1);
	endtask

	task automatic checkData(input string name, input logic [DataWidth-1:0] got,
			input logic [DataWidth-1:0] exp);
		if (got !== exp)
			failNow($sformatf("Error at %0t: %s is %h, expected %h", $time, name, got, exp));
	endtask

	task automatic checkPhaseFlag(input string name, input logic got, input logic exp);
		if (got !== exp)
			failNow($sformatf("Error at %0t: %s is %b, expected %b", $time, name, got, exp));
	endtask

	task automatic checkIdleFlags();
		checkPhaseFlag("busy", busy, 1'b0);
		checkPhaseFlag("encValid", encValid, 1'b0);
		checkPhaseFlag("stashOutValid", stashOutValid, 1'b0);
	endtask

	// Words in one access block, zero for a bad mode word
	function automatic int blockWords(input logic [31:0] modeWord);
		if (modeWord === 32'(modeReadWrite)) return HeadWords + 2 * PathBursts;
		else if (modeWord === 32'(modeReadOnly)) return HeadWords + Headers;
		else return 0;
	endfunction

	//==========================================================================
	// One access: start, decryptor burst, drain and fill, writeback
	//==========================================================================

	task automatic runAccess(input int at);
		accessModeT accMode;
		accessModeT otherMode;
		int         decCount;
		int         stashCount;
		int         drainGoal;
		int         encGoal;
		accMode    = accessModeT'(testMem[at][1:0]);
		otherMode  = (accMode == modeReadWrite) ? modeReadOnly : modeReadWrite;
		decCount   = (accMode == modeReadWrite) ? PathBursts : Headers;
		stashCount = (accMode == modeReadWrite) ? PathBursts : 0;

		@(negedge Clock);                               // Ready settings change between edges
		readyRandom = testMem[at + 1][0];
		readyMask   = testMem[at + 2];

		@(posedge Clock);
		mode  <= accMode;
		start <= 1'b1;
		drainGoal = drainSeen + ((accMode == modeReadWrite) ? PathBursts : 0);
		encGoal   = encSeen + ((accMode == modeReadWrite) ? stashCount : decCount);
		for (int i = 0; i < decCount; i++) begin
			if (accMode == modeReadWrite) expDrain.push_back(testMem[at + HeadWords + i]);
			else expEnc.push_back(testMem[at + HeadWords + i]);   // Headers go straight back
		end
		for (int i = 0; i < stashCount; i++)
			expEnc.push_back(testMem[at + HeadWords + decCount + i]);

		for (int i = 0; i < decCount; i++) begin
			@(posedge Clock);
			start    <= (i == 1);                       // Start while busy, to be ignored
			mode     <= (i == 1) ? otherMode : modeIdle;
			decValid <= 1'b1;
			decData  <= testMem[at + HeadWords + i];
		end
		@(posedge Clock);
		start    <= 1'b0;
		mode     <= modeIdle;
		decValid <= 1'b0;

		if (accMode == modeReadWrite) begin
			while (drainSeen < drainGoal) @(posedge Clock);   // Fill only after the drain
			for (int i = 0; i < stashCount; i++) begin
				stashValid <= 1'b1;
				stashData  <= testMem[at + HeadWords + decCount + i];
				@(posedge Clock);
			end
			stashValid <= 1'b0;
		end

		while (encSeen < encGoal || busy) @(posedge Clock);
		@(negedge Clock);
		checkIdleFlags();
	endtask

	//==========================================================================
	// Encryptor ready, output monitor and cycle limit
	//==========================================================================

	initial begin
		void'($urandom(Seed));
		forever begin
			@(posedge Clock);
			if (readyRandom) encReady <= 1'($urandom);
			else encReady <= readyMask[readyPhase];     // Mask bit per cycle
			readyPhase <= readyPhase + 1'b1;
		end
	end

	// Outputs sampled between edges
	always @(negedge Clock) begin
		if (rstN && stashOutValid) begin
			if (expDrain.size() == 0) failNow("stash output word seen with none expected");
			else begin
				checkData("stashOutData", stashOutData, expDrain.pop_front());
				drainSeen++;
			end
		end
		if (rstN && encValid && encReady) begin
			if (expEnc.size() == 0) failNow("encryptor accepted a word with none expected");
			else begin
				checkData("encData", encData, expEnc.pop_front());
				encSeen++;
			end
		end
	end

	always @(posedge Clock) begin
		cycleCount++;
		if (timeoutLimit > 0 && cycleCount > timeoutLimit)
			failNow($sformatf("timeout, run not finished within %0d cycles", timeoutLimit));
	end

	//==========================================================================
	// Main sequence
	//==========================================================================

	initial begin
		int dataWords;
		int scan;
		mode       = modeIdle;
		start      = 1'b0;
		decValid   = 1'b0;
		decData    = '0;
		stashValid = 1'b0;
		stashData  = '0;
		encReady   = 1'b0;

		$readmemh("tb/pathBufferTests.txt", testMem);
		dataWords = 0;
		scan      = 0;
		while (scan < TestWords && testMem[scan] !== 32'd0) begin
			if (blockWords(testMem[scan]) == 0)
				failNow($sformatf("tests file has a bad mode word at offset %0d", scan));
			else begin
				dataWords += blockWords(testMem[scan]) - HeadWords;
				scan      += blockWords(testMem[scan]);
			end
		end
		if (dataWords == 0) failNow("tests file holds no accesses");
		timeoutLimit = dataWords * 8 + 100;

		while (!rstN) @(posedge Clock);
		@(negedge Clock);
		checkIdleFlags();                               // State right after reset

		base        = 0;
		accessCount = 0;
		while (base < TestWords && testMem[base] !== 32'd0) begin
			runAccess(base);
			base += blockWords(testMem[base]);
			accessCount++;
		end
		$display("%0d accesses run in %0d cycles", accessCount, cycleCount);

		if (expDrain.size() != 0 || expEnc.size() != 0)
			failNow("words were expected but never seen");
		else begin
			$display("TESTBENCH PASSED");
			$finish;
		end
	end

endmodule

// ==== tb/tbClockGen.sv ====
//==========================================================================
// Testbench clock and reset source: period 8, reset low for 3 cycles
//==========================================================================

module tbClockGen (
	output logic Clock,
	output logic rstN
);

	initial begin
		Clock = 1'b0;
		forever #4 Clock = ~Clock;              // Period 8
	end

	initial begin
		rstN = 1'b0;
		repeat (3) @(posedge Clock);            // Low across three edges
		rstN <= 1'b1;
	end

endmodule

// ==== logic/pathBufferTop.sv ====
//==========================================================================
// Path buffer subsystem top: port arbiter, path buffer RAM and
// encryptor input queue
//==========================================================================

module pathBufferTop import oramPathPkg::*; #(
	parameter int DataWidth    = 32,
	parameter int TreeLevels   = 3,
	parameter int BucketBursts = 4,
	parameter int QueueDepth   = 4,
	localparam int AddrWidth   = addrWidthOf(TreeLevels, BucketBursts)
) (
	input  logic                 Clock,
	input  logic                 rstN,
	input  accessModeT           mode,
	input  logic                 start,
	input  logic                 decValid,
	input  logic [DataWidth-1:0] decData,
	input  logic                 stashValid,
	input  logic [DataWidth-1:0] stashData,
	input  logic                 encReady,
	output logic                 stashOutValid,
	output logic [DataWidth-1:0] stashOutData,
	output logic                 encValid,
	output logic [DataWidth-1:0] encData,
	output logic                 busy
);

	logic                 bufEnable;
	logic                 bufWrite;
	logic [AddrWidth-1:0] bufAddr;
	logic [DataWidth-1:0] bufDIn;
	logic [DataWidth-1:0] bufDOut;
	logic                 qPush;
	logic                 creditReturn;

	assign stashOutData = bufDOut;                  // Drain data straight from RAM

	pathPortArbiter #(
		.DataWidth(DataWidth),
		.TreeLevels(TreeLevels),
		.BucketBursts(BucketBursts),
		.QueueDepth(QueueDepth)
	) u_arbiter (
		.Clock(Clock),
		.rstN(rstN),
		.mode(mode),
		.start(start),
		.decValid(decValid),
		.decData(decData),
		.stashValid(stashValid),
		.stashData(stashData),
		.creditReturn(creditReturn),
		.bufEnable(bufEnable),
		.bufWrite(bufWrite),
		.bufAddr(bufAddr),
		.bufDIn(bufDIn),
		.qPush(qPush),
		.stashOutValid(stashOutValid),
		.busy(busy)
	);

	pathBuffer #(
		.DataWidth(DataWidth),
		.TreeLevels(TreeLevels),
		.BucketBursts(BucketBursts)
	) u_buffer (
		.Clock(Clock),
		.bufEnable(bufEnable),
		.bufWrite(bufWrite),
		.bufAddr(bufAddr),
		.bufDIn(bufDIn),
		.bufDOut(bufDOut)
	);

	encInputQueue #(
		.DataWidth(DataWidth),
		.QueueDepth(QueueDepth)
	) u_queue (
		.Clock(Clock),
		.rstN(rstN),
		.qPush(qPush),
		.qData(bufDOut),                            // Writeback reads
		.encReady(encReady),
		.encValid(encValid),
		.encData(encData),
		.creditReturn(creditReturn)
	);

endmodule

// ==== logic/encInputQueue.sv ====
//==========================================================================
// Encryptor input FIFO, filled from path buffer reads, one credit
// returned to the arbiter per encryptor handshake
//==========================================================================

module encInputQueue import oramPathPkg::*; #(
	parameter int DataWidth  = 32,
	parameter int QueueDepth = 4
) (
	input  logic                 Clock,
	input  logic                 rstN,
	input  logic                 qPush,
	input  logic [DataWidth-1:0] qData,
	input  logic                 encReady,
	output logic                 encValid,
	output logic [DataWidth-1:0] encData,
	output logic                 creditReturn
);

	localparam int PtrWidth   = widthOf(QueueDepth);
	localparam int CountWidth = widthOf(QueueDepth + 1);

	logic [DataWidth-1:0]  entries [QueueDepth];
	logic [PtrWidth-1:0]   wrPtr;
	logic [PtrWidth-1:0]   rdPtr;
	logic [CountWidth-1:0] fill;
	logic                  pop;

	// Wrap explicitly so any depth works
	function automatic logic [PtrWidth-1:0] nextPtr(input logic [PtrWidth-1:0] ptr);
		return (ptr == PtrWidth'(QueueDepth - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign encValid     = fill != '0;
	assign encData      = entries[rdPtr];           // Head of queue
	assign pop          = encValid && encReady;
	assign creditReturn = pop;                      // One credit per pop

	always_ff @(posedge Clock) begin
		if (qPush) begin
			entries[wrPtr] <= qData;
		end
	end

	//==========================================================================
	// Pointers and fill level
	//==========================================================================

	always_ff @(posedge Clock) begin
		if (!rstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			fill  <= '0;
		end else begin
			if (qPush) wrPtr <= nextPtr(wrPtr);
			if (pop) rdPtr <= nextPtr(rdPtr);
			unique case ({qPush, pop})
				2'b10: begin
					fill <= fill + 1'b1;
				end
				2'b01: begin
					fill <= fill - 1'b1;
				end
				default: begin
					fill <= fill;               // Idle or push with pop
				end
			endcase
		end
	end

	// Arbiter credits must keep a full queue from seeing a push
	noPushWhenFull: assert property (@(posedge Clock) disable iff (!rstN)
		qPush |-> fill != CountWidth'(QueueDepth))
		else $error("push into full encryptor queue");

endmodule

// ==== logic/pathBuffer.sv ====
//==========================================================================
// Single-port path buffer RAM: input path, output path and header
// regions, one-cycle read latency
//==========================================================================

module pathBuffer import oramPathPkg::*; #(
	parameter int DataWidth    = 32,
	parameter int TreeLevels   = 3,
	parameter int BucketBursts = 4,
	localparam int BufWords    = bufWordsOf(TreeLevels, BucketBursts),
	localparam int AddrWidth   = addrWidthOf(TreeLevels, BucketBursts)
) (
	input  logic                 Clock,
	input  logic                 bufEnable,
	input  logic                 bufWrite,
	input  logic [AddrWidth-1:0] bufAddr,
	input  logic [DataWidth-1:0] bufDIn,
	output logic [DataWidth-1:0] bufDOut
);

	logic [DataWidth-1:0] mem [BufWords];

	always_ff @(posedge Clock) begin
		if (bufEnable) begin
			if (bufWrite) begin
				mem[bufAddr] <= bufDIn;
			end else begin
				bufDOut <= mem[bufAddr];        // Holds until next read
			end
		end
	end

	// Arbiter address map must stay inside the three regions
	addrInRange: assert property (@(posedge Clock)
		bufEnable |-> bufAddr < AddrWidth'(BufWords))
		else $error("path buffer address out of range");

endmodule

// ==== logic/pathPortArbiter.sv ====
//==========================================================================
// Port arbiter for the path buffer: phase FSM, shared burst counter,
// buffer address map, read-delay flags and encryptor credit counter
//==========================================================================

module pathPortArbiter import oramPathPkg::*; #(
	parameter int DataWidth    = 32,
	parameter int TreeLevels   = 3,
	parameter int BucketBursts = 4,
	parameter int QueueDepth   = 4,
	localparam int PathBursts  = pathBurstsOf(TreeLevels, BucketBursts),
	localparam int AddrWidth   = addrWidthOf(TreeLevels, BucketBursts)
) (
	input  logic                 Clock,
	input  logic                 rstN,
	input  accessModeT           mode,
	input  logic                 start,
	input  logic                 decValid,
	input  logic [DataWidth-1:0] decData,
	input  logic                 stashValid,
	input  logic [DataWidth-1:0] stashData,
	input  logic                 creditReturn,
	output logic                 bufEnable,
	output logic                 bufWrite,
	output logic [AddrWidth-1:0] bufAddr,
	output logic [DataWidth-1:0] bufDIn,
	output logic                 qPush,
	output logic                 stashOutValid,
	output logic                 busy
);

	localparam int CountWidth  = widthOf(PathBursts);
	localparam int CreditWidth = widthOf(QueueDepth + 1);

	localparam logic [AddrWidth-1:0] InBase  = AddrWidth'(InBaseAddr);
	localparam logic [AddrWidth-1:0] OutBase = AddrWidth'(outBaseOf(PathBursts));
	localparam logic [AddrWidth-1:0] HdrBase = AddrWidth'(hdrBaseOf(PathBursts));

	phaseT                  phase;
	accessModeT             activeMode;         // Mode latched at start
	logic [CountWidth-1:0]  burstCount;
	logic [CountWidth-1:0]  lastCount;
	logic                   atLast;
	logic                   readOnly;
	logic                   allIssued;          // Every writeback read issued
	logic                   issue;
	logic                   bufRead;
	logic                   lastPop;
	logic [AddrWidth-1:0]   regionBase;
	logic [CreditWidth-1:0] credits;
	logic [CreditWidth-1:0] outstanding;        // Issued, not yet popped

	//==========================================================================
	// Port ownership and address map
	//==========================================================================

	assign readOnly  = activeMode == modeReadOnly;
	assign lastCount = readOnly ? CountWidth'(TreeLevels) : CountWidth'(PathBursts - 1);
	assign atLast    = burstCount == lastCount;
	assign issue     = (phase == phWriteback) && !allIssued && (credits != '0);

	always_comb begin
		bufEnable  = 1'b0;
		bufWrite   = 1'b0;
		regionBase = InBase;
		unique case (phase)
			phPathRead: begin
				bufEnable  = decValid;                  // No back-pressure on decryptor
				bufWrite   = 1'b1;
				regionBase = readOnly ? HdrBase : InBase;
			end
			phStashDrain: begin
				bufEnable  = 1'b1;                      // One read per cycle
				regionBase = InBase;
			end
			phStashFill: begin
				bufEnable  = stashValid;
				bufWrite   = 1'b1;
				regionBase = OutBase;
			end
			phWriteback: begin
				bufEnable  = issue;                     // Credit limited
				regionBase = readOnly ? HdrBase : OutBase;
			end
			default: begin
				bufEnable  = 1'b0;
			end
		endcase
	end

	assign bufAddr = regionBase + AddrWidth'(burstCount);
	assign bufDIn  = (phase == phPathRead) ? decData : stashData;
	assign bufRead = bufEnable && !bufWrite;
	assign busy    = (phase != phIdle) && (phase != phDone);
	assign lastPop = allIssued && creditReturn && (outstanding == CreditWidth'(1));

	//==========================================================================
	// Phase FSM and shared burst counter
	//==========================================================================

	always_ff @(posedge Clock) begin
		if (!rstN) begin
			phase      <= phIdle;
			activeMode <= modeIdle;
			burstCount <= '0;
			allIssued  <= 1'b0;
		end else begin
			unique case (phase)
				phIdle: begin
					if (start && (mode != modeIdle)) begin
						activeMode <= mode;
						burstCount <= '0;
						allIssued  <= 1'b0;
						phase      <= phPathRead;
					end
				end
				phPathRead: begin
					if (decValid) begin
						if (atLast) begin
							burstCount <= '0;
							phase      <= readOnly ? phWriteback : phStashDrain;
						end else begin
							burstCount <= burstCount + 1'b1;
						end
					end
				end
				phStashDrain: begin
					if (atLast) begin
						burstCount <= '0;
						phase      <= phStashFill;
					end else begin
						burstCount <= burstCount + 1'b1;
					end
				end
				phStashFill: begin
					if (stashValid) begin
						if (atLast) begin
							burstCount <= '0;
							phase      <= phWriteback;
						end else begin
							burstCount <= burstCount + 1'b1;
						end
					end
				end
				phWriteback: begin
					if (issue) begin
						if (atLast) allIssued <= 1'b1;
						else burstCount <= burstCount + 1'b1;
					end
					if (lastPop) phase <= phDone;   // Last word left the queue
				end
				phDone: begin
					phase <= phIdle;
				end
				default: begin
					phase <= phIdle;
				end
			endcase
		end
	end

	// Read data appears one cycle after enable
	always_ff @(posedge Clock) begin
		if (!rstN) begin
			stashOutValid <= 1'b0;
			qPush         <= 1'b0;
		end else begin
			stashOutValid <= bufRead && (phase == phStashDrain);
			qPush         <= bufRead && (phase == phWriteback);
		end
	end

	//==========================================================================
	// Encryptor credits
	//==========================================================================

	always_ff @(posedge Clock) begin
		if (!rstN) begin
			credits     <= CreditWidth'(QueueDepth);
			outstanding <= '0;
		end else begin
			unique case ({issue, creditReturn})
				2'b10: begin
					credits     <= credits - 1'b1;
					outstanding <= outstanding + 1'b1;
				end
				2'b01: begin
					credits     <= credits + 1'b1;
					outstanding <= outstanding - 1'b1;
				end
				default: begin
					credits     <= credits;         // Issue and return cancel
				end
			endcase
		end
	end

	creditBound: assert property (@(posedge Clock) disable iff (!rstN)
		credits <= CreditWidth'(QueueDepth))
		else $error("credit count above queue depth");

	stashOnlyInFill: assert property (@(posedge Clock) disable iff (!rstN)
		stashValid |-> phase == phStashFill)
		else $error("stashValid outside stash fill phase");

endmodule

// ==== logic/oramPathPkg.sv ====
//==========================================================================
// Shared types for the path buffer port subsystem: access modes, arbiter
// phases and helpers for the buffer size and region base addresses
//==========================================================================

package oramPathPkg;

	typedef enum logic [1:0] {
		modeIdle      = 2'd0,                   // No access
		modeReadWrite = 2'd1,                   // Full path access
		modeReadOnly  = 2'd2                    // Header-only access
	} accessModeT;

	typedef enum logic [2:0] {
		phIdle       = 3'd0,
		phPathRead   = 3'd1,                    // Decryptor fills buffer
		phStashDrain = 3'd2,                    // Input region to stash
		phStashFill  = 3'd3,                    // Stash fills output region
		phWriteback  = 3'd4,                    // Buffer to encryptor queue
		phDone       = 3'd5
	} phaseT;

	localparam int InBaseAddr = 0;              // Input path region start

	function automatic int widthOf(input int n);
		return (n > 1) ? $clog2(n) : 1;
	endfunction

	function automatic int pathBurstsOf(input int treeLevels, input int bucketBursts);
		return (treeLevels + 1) * bucketBursts;
	endfunction

	// Input path, output path, then one header burst per bucket
	function automatic int bufWordsOf(input int treeLevels, input int bucketBursts);
		return 2 * pathBurstsOf(treeLevels, bucketBursts) + treeLevels + 1;
	endfunction

	function automatic int addrWidthOf(input int treeLevels, input int bucketBursts);
		return widthOf(bufWordsOf(treeLevels, bucketBursts));
	endfunction

	function automatic int outBaseOf(input int pathBursts);
		return pathBursts;
	endfunction

	function automatic int hdrBaseOf(input int pathBursts);
		return 2 * pathBursts;
	endfunction

endpackage
